//--- aesCore.f
source/aesPkg.sv
source/aesKeySchedule.sv
source/aesRoundDatapath.sv
source/aesApbRegs.sv
source/aesApbTop.sv
bench/aesTb.sv

//--- Bender.yml
package:
  name: aesCore

sources:
  - files:
      - source/aesPkg.sv
      - source/aesKeySchedule.sv
      - source/aesRoundDatapath.sv
      - source/aesApbRegs.sv
      - source/aesApbTop.sv
  - target: simulation
    files:
      - bench/aesTb.sv

//--- bench/aesTb.sv
// testbench for the APB AES-128 core
//   clock, reset, APB access tasks, reference AES-128 model
//   reset, known vector, random, stall, error and busy window tests
//   queued compare process, error count and summary

`timescale 1ns/1ps

module aesTb;

  localparam int maxCycles = 3000;  // 24 runs at about 60 cycles each plus margin

  logic             clk, reset, psel, penable, pwrite, pready, pslverr;
  aesPkg::apbAddr_t paddr;
  aesPkg::word_t    pwdata, prdata;

  integer         seed;
  int             cycles, errors, checks;
  string          nameQ[$];               // pending compares
  logic [127:0]   expQ[$], actQ[$];
  aesPkg::block_t curKey, curPlain, curCipher;  // expected register contents

  aesApbTop i_aesApbTop (
    .clk     (clk),
    .reset   (reset),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  always #2 clk = ~clk;  // 4 ns period

  // run limit
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= maxCycles) begin
      $display("timeout, run did not finish within %0d cycles", maxCycles);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // drains the compare queues
  always begin : compare
    string        n;
    logic [127:0] e, a;
    wait (actQ.size() > 0);
    n = nameQ.pop_front();
    e = expQ.pop_front();
    a = actQ.pop_front();
    checks = checks + 1;
    assert (a === e) else begin
      errors = errors + 1;
      $display("Error at %0t: %s expected %0h got %0h", $time, n, e, a);
    end
  end

  function automatic aesPkg::byte_t mulTwo(input aesPkg::byte_t x);
    return {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);
  endfunction

  // textbook AES-128 with the full key expansion up front
  function automatic aesPkg::block_t aesEncryptRef(input aesPkg::block_t key,
                                                   input aesPkg::block_t pt);
    aesPkg::byte_t  st [16];   // index 4*col + row
    aesPkg::byte_t  tmp [16];
    aesPkg::word_t  w [44];
    aesPkg::word_t  t;
    aesPkg::byte_t  rcon;
    aesPkg::block_t res;
    for (int i = 0; i < 4; i++) w[i] = key[127 - 32*i -: 32];
    rcon = 8'h01;
    for (int i = 4; i < 44; i++) begin
      t = w[i-1];
      if (i % 4 == 0) begin
        t = {aesPkg::sbox(t[23:16]) ^ rcon, aesPkg::sbox(t[15:8]),
             aesPkg::sbox(t[7:0]), aesPkg::sbox(t[31:24])};
        rcon = aesPkg::rconNext(rcon);
      end
      w[i] = w[i-4] ^ t;
    end
    for (int b = 0; b < 16; b++) st[b] = pt[127 - 8*b -: 8] ^ key[127 - 8*b -: 8];
    for (int r = 1; r <= 10; r++) begin
      for (int c = 0; c < 4; c++)  // SubBytes and ShiftRows together
        for (int row = 0; row < 4; row++)
          tmp[4*c + row] = aesPkg::sbox(st[4*((c + row) % 4) + row]);
      for (int c = 0; c < 4; c++) begin
        for (int row = 0; row < 4; row++) begin
          if (r < 10)  // 2a0 ^ 3a1 ^ a2 ^ a3 rotated per row
            st[4*c + row] = mulTwo(tmp[4*c + row]) ^ mulTwo(tmp[4*c + (row+1)%4])
                            ^ tmp[4*c + (row+1)%4] ^ tmp[4*c + (row+2)%4]
                            ^ tmp[4*c + (row+3)%4];
          else
            st[4*c + row] = tmp[4*c + row];  // no mix in the last round
          st[4*c + row] = st[4*c + row] ^ w[4*r + c][31 - 8*row -: 8];
        end
      end
    end
    for (int b = 0; b < 16; b++) res[127 - 8*b -: 8] = st[b];
    return res;
  endfunction

  task automatic expectValue(input string name, input logic [127:0] exp, act);
    nameQ.push_back(name);
    expQ.push_back(exp);
    actQ.push_back(act);  // last push wakes the compare process
  endtask

  // one APB transfer entered and left at edge + 0.5 ns
  task automatic apbAccess(input logic wr, input aesPkg::apbAddr_t addr,
                           input aesPkg::word_t data, output aesPkg::word_t rdata,
                           output logic err, output logic stalled);
    stalled = 1'b0;
    psel    = 1'b1;  // setup phase
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = data;
    @(posedge clk);
    #0.5 penable = 1'b1;
    #1;  // sample well before the edge
    while (!pready) begin
      stalled = 1'b1;
      @(posedge clk);
      #1.5;
    end
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);  // transfer completes here
    #0.5;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic writeWord(input aesPkg::apbAddr_t addr, input aesPkg::word_t data);
    aesPkg::word_t rd;
    logic          err, stalled;
    apbAccess(1'b1, addr, data, rd, err, stalled);
    expectValue("pslverr", 0, err);
    expectValue("stalled", 0, stalled);  // core idle here
  endtask

  task automatic readWord(input aesPkg::apbAddr_t addr, output aesPkg::word_t data);
    logic err, stalled;
    apbAccess(1'b0, addr, '0, data, err, stalled);
    expectValue("pslverr", 0, err);
    expectValue("stalled", 0, stalled);  // reads never stall
  endtask

  task automatic writeBlock(input aesPkg::apbAddr_t base, input aesPkg::block_t b);
    for (int i = 0; i < 4; i++) writeWord(base + 8'(4*i), b[127 - 32*i -: 32]);  // msw first
  endtask

  task automatic checkBlock(input string name, input aesPkg::apbAddr_t base,
                            input aesPkg::block_t exp);
    aesPkg::word_t  w;
    aesPkg::block_t b;
    for (int i = 0; i < 4; i++) begin
      readWord(base + 8'(4*i), w);
      b[127 - 32*i -: 32] = w;
    end
    expectValue(name, exp, b);
  endtask

  task automatic checkRegs();
    checkBlock("cipherKey", aesPkg::addrKey, curKey);
    checkBlock("plainText", aesPkg::addrPlain, curPlain);
    checkBlock("cipherText", aesPkg::addrCipher, curCipher);
  endtask

  task automatic randBlock(output aesPkg::block_t b);
    b = {$random(seed), $random(seed), $random(seed), $random(seed)};
  endtask

  // start then poll status back to back and check all registers
  task automatic startAndWait();
    aesPkg::word_t st;
    bit            first;
    first = 1'b1;
    writeWord(aesPkg::addrCtrl, 32'h1);
    do begin
      readWord(aesPkg::addrStatus, st);
      if (first) expectValue("status", 32'h1, st);  // busy right after start
      first = 1'b0;
      assert (st == 32'h1 || st == 32'h2) else begin
        errors = errors + 1;
        $display("Error at %0t: status expected 1 or 2 got %0h", $time, st);
      end
    end while (!st[1]);
    curCipher = aesEncryptRef(curKey, curPlain);
    checkRegs();
  endtask

  task automatic runVector(input aesPkg::block_t k, p);
    writeBlock(aesPkg::addrKey, k);
    writeBlock(aesPkg::addrPlain, p);
    curKey   = k;
    curPlain = p;
    startAndWait();
  endtask

  initial begin
    aesPkg::block_t k, p;
    aesPkg::word_t  st, rd;
    logic           err, stalled;
    clk = 1'b0;
    reset = 1'b1;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    seed = 32'h874db2dc;
    cycles = 0;
    errors = 0;
    checks = 0;
    curKey = '0;
    curPlain = '0;
    curCipher = '0;
    repeat (3) @(posedge clk);
    #0.5 reset = 1'b0;

    readWord(aesPkg::addrStatus, st);  // everything zero after reset
    expectValue("status", 0, st);
    checkRegs();

    // FIPS-197 appendix B vector
    k = 128'h2b7e151628aed2a6abf7158809cf4f3c;
    p = 128'h3243f6a8885a308d313198a2e0370734;
    expectValue("aesEncryptRef", 128'h3925841d02dc09fbdc118597196a0b32, aesEncryptRef(k, p));
    runVector(k, p);
    readWord(aesPkg::addrStatus, st);
    expectValue("status", 32'h2, st);

    repeat (20) begin
      randBlock(k);
      randBlock(p);
      runVector(k, p);
    end

    // plaintext write right behind a start must stall
    randBlock(p);
    writeBlock(aesPkg::addrPlain, p);
    curPlain = p;
    writeWord(aesPkg::addrCtrl, 32'h1);
    apbAccess(1'b1, aesPkg::addrPlain, ~p[127:96], rd, err, stalled);
    assert (stalled) else begin
      errors = errors + 1;
      $display("plaintext write during encryption completed without a stall");
    end
    expectValue("pslverr", 0, err);
    readWord(aesPkg::addrStatus, st);
    expectValue("status", 32'h2, st);
    curCipher = aesEncryptRef(curKey, curPlain);  // old plaintext used
    curPlain[127:96] = ~p[127:96];
    checkRegs();
    startAndWait();  // new plaintext this time

    // bad accesses answer with pslverr and change nothing
    apbAccess(1'b1, aesPkg::addrCipher + 8'h4, 32'hdeadbeef, rd, err, stalled);
    expectValue("pslverr", 1, err);
    apbAccess(1'b1, aesPkg::addrStatus, 32'h3, rd, err, stalled);
    expectValue("pslverr", 1, err);
    apbAccess(1'b0, 8'h40, '0, rd, err, stalled);  // unmapped
    expectValue("pslverr", 1, err);
    apbAccess(1'b1, 8'h3c, 32'h1, rd, err, stalled);
    expectValue("pslverr", 1, err);
    readWord(aesPkg::addrStatus, st);
    expectValue("status", 32'h2, st);
    checkRegs();

    wait (actQ.size() == 0);
    #1;
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

//--- source/aesApbTop.sv
// aesApbTop
//   AES-128 encryption core behind an APB3 slave
//   register block, key schedule and round datapath

`timescale 1ns/1ps

module aesApbTop (
  input  logic             clk,
  input  logic             reset,
  input  logic             psel,
  input  logic             penable,
  input  logic             pwrite,
  input  aesPkg::apbAddr_t paddr,
  input  aesPkg::word_t    pwdata,
  output aesPkg::word_t    prdata,
  output logic             pready,
  output logic             pslverr
);

  logic           start, finalRound, cipherValid;
  aesPkg::block_t cipherKey, plainText, roundKey, cipherText;

  // register block, drives start and the operands
  aesApbRegs i_aesApbRegs (
    .clk         (clk),
    .reset       (reset),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .cipherText  (cipherText),
    .cipherValid (cipherValid),
    .prdata      (prdata),
    .pready      (pready),
    .pslverr     (pslverr),
    .start       (start),
    .cipherKey   (cipherKey),
    .plainText   (plainText)
  );

  // runs in lockstep with the datapath
  aesKeySchedule i_aesKeySchedule (
    .clk        (clk),
    .reset      (reset),
    .start      (start),
    .cipherKey  (cipherKey),
    .roundKey   (roundKey),
    .finalRound (finalRound)
  );

  aesRoundDatapath i_aesRoundDatapath (
    .clk         (clk),
    .reset       (reset),
    .start       (start),
    .plainText   (plainText),
    .cipherKey   (cipherKey),
    .roundKey    (roundKey),
    .finalRound  (finalRound),
    .cipherText  (cipherText),
    .cipherValid (cipherValid)
  );

endmodule

//--- source/aesApbRegs.sv
// APB3 slave for the AES core
//   key, plaintext, ciphertext, control and status registers
//   start pulse, busy and done flags, write stall while busy
//   pslverr on unmapped or read-only writes

`timescale 1ns/1ps

module aesApbRegs (
  input  logic             clk,
  input  logic             reset,
  input  logic             psel,
  input  logic             penable,
  input  logic             pwrite,
  input  aesPkg::apbAddr_t paddr,
  input  aesPkg::word_t    pwdata,
  input  aesPkg::block_t   cipherText,
  input  logic             cipherValid,
  output aesPkg::word_t    prdata,
  output logic             pready,
  output logic             pslverr,
  output logic             start,
  output aesPkg::block_t   cipherKey,
  output aesPkg::block_t   plainText
);

  aesPkg::block_t cipherReg;  // latched result
  logic           busyReg, doneReg;
  logic           busy, done;
  logic           access, aligned;
  logic           isKey, isPlain, isCipher, isCtrl, isStatus;
  logic           mapped, badAccess, stallRegion, wrEn;
  logic [1:0]     wordSel;    // word 0 is most significant

  // address decode
  assign aligned  = (paddr[1:0] == 2'b00);
  assign isKey    = aligned && (paddr[7:4] == aesPkg::addrKey[7:4]);
  assign isPlain  = aligned && (paddr[7:4] == aesPkg::addrPlain[7:4]);
  assign isCipher = aligned && (paddr[7:4] == aesPkg::addrCipher[7:4]);
  assign isCtrl   = (paddr == aesPkg::addrCtrl);
  assign isStatus = (paddr == aesPkg::addrStatus);
  assign mapped   = isKey | isPlain | isCipher | isCtrl | isStatus;
  assign wordSel  = ~paddr[3:2];  // bit offset = wordSel * 32

  assign badAccess   = !mapped || (pwrite && (isCipher || isStatus));
  assign stallRegion = isKey | isPlain | isCtrl;

  assign access  = psel & penable;
  // writes to core inputs wait out the encryption
  assign pready  = !(access && pwrite && stallRegion && busy);
  assign pslverr = access && badAccess;
  assign wrEn    = access && pwrite && pready && !badAccess;

  // busy covers S..S+10 and done starts at S+11
  assign busy = start | (busyReg & ~cipherValid);
  assign done = cipherValid | (doneReg & ~start);

  always_ff @(posedge clk) begin
    if (reset) begin
      busyReg <= 1'b0;
      doneReg <= 1'b0;
    end else if (start) begin
      busyReg <= 1'b1;
      doneReg <= 1'b0;  // new run clears done
    end else if (cipherValid) begin
      busyReg <= 1'b0;
      doneReg <= 1'b1;
    end
  end

  // start one cycle after the completing ctrl write
  always_ff @(posedge clk) begin
    if (reset) begin
      start <= 1'b0;
    end else begin
      start <= wrEn && isCtrl && pwdata[0];
    end
  end

  // key and plaintext words
  always_ff @(posedge clk) begin
    if (reset) begin
      cipherKey <= '0;
      plainText <= '0;
    end else if (wrEn) begin
      if (isKey) cipherKey[{wordSel, 5'b0} +: 32] <= pwdata;
      if (isPlain) plainText[{wordSel, 5'b0} +: 32] <= pwdata;
    end
  end

  // ciphertext latch
  always_ff @(posedge clk) begin
    if (reset) begin
      cipherReg <= '0;
    end else if (cipherValid) begin
      cipherReg <= cipherText;
    end
  end

  // read mux where ctrl reads back zero
  always_comb begin
    prdata = '0;
    if (psel && !pwrite) begin
      if (isKey) begin
        prdata = cipherKey[{wordSel, 5'b0} +: 32];
      end else if (isPlain) begin
        prdata = plainText[{wordSel, 5'b0} +: 32];
      end else if (isCipher) begin
        prdata = cipherReg[{wordSel, 5'b0} +: 32];
      end else if (isStatus) begin
        prdata = {30'b0, done, busy};
      end
    end
  end

  // an erroring access completes at once and writes nothing
  slverrOnComplete: assert property (
    @(posedge clk) disable iff (reset)
      pslverr |-> pready ##1 ($stable(cipherKey) && $stable(plainText) && !start)
  );

endmodule

//--- source/aesRoundDatapath.sv
// iterative AES-128 cipher with one full round per clock
//   SubBytes, ShiftRows, MixColumns, AddRoundKey on the state register
//   round FSM idle/round/finish with cipherValid pulse

`timescale 1ns/1ps

module aesRoundDatapath (
  input  logic           clk,
  input  logic           reset,
  input  logic           start,
  input  aesPkg::block_t plainText,
  input  aesPkg::block_t cipherKey,
  input  aesPkg::block_t roundKey,
  input  logic           finalRound,
  output aesPkg::block_t cipherText,
  output logic           cipherValid
);

  typedef enum logic [1:0] {idle, round, finish} fsmState_t;

  fsmState_t      fsm, nextFsm;
  aesPkg::block_t stateReg;  // AES state with byte 0 at the top
  aesPkg::block_t subOut, shiftOut, mixOut, roundOut;

  // GF(2^8) doubling as in the rcon step
  function automatic aesPkg::byte_t xtime(aesPkg::byte_t b);
    return aesPkg::rconNext(b);
  endfunction

  // MixColumns of one column in xtime form
  function automatic aesPkg::word_t mixColumn(aesPkg::word_t col);
    aesPkg::byte_t a0, a1, a2, a3, t;
    a0 = col[31:24];
    a1 = col[23:16];
    a2 = col[15:8];
    a3 = col[7:0];
    t  = a0 ^ a1 ^ a2 ^ a3;  // shared sum
    return {a0 ^ t ^ xtime(a0 ^ a1),
            a1 ^ t ^ xtime(a1 ^ a2),
            a2 ^ t ^ xtime(a2 ^ a3),
            a3 ^ t ^ xtime(a3 ^ a0)};
  endfunction

  // SubBytes as sixteen table lookups
  always_comb begin
    for (int i = 0; i < 16; i++) begin
      subOut[8*i +: 8] = aesPkg::sbox(stateReg[8*i +: 8]);
    end
  end

  // ShiftRows rotates row r left by r
  always_comb begin
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        shiftOut[127 - 8*(4*c + r) -: 8] = subOut[127 - 8*(4*((c + r) % 4) + r) -: 8];
      end
    end
  end

  // MixColumns per column
  always_comb begin
    for (int c = 0; c < 4; c++) begin
      mixOut[127 - 32*c -: 32] = mixColumn(shiftOut[127 - 32*c -: 32]);
    end
  end

  assign roundOut = finalRound ? shiftOut : mixOut;  // last round skips mix

  // next state logic
  always_comb begin
    nextFsm = fsm;
    case (fsm)
      idle:    if (start) nextFsm = round;
      round:   if (finalRound) nextFsm = finish;  // round 10 in progress
      finish:  nextFsm = idle;
      default: nextFsm = idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      fsm <= idle;
    end else begin
      fsm <= nextFsm;
    end
  end

  // state register loads on start and each round
  always_ff @(posedge clk) begin
    if (start) begin
      stateReg <= plainText ^ cipherKey;  // initial AddRoundKey
    end else if (fsm == round) begin
      stateReg <= roundOut ^ roundKey;    // rounds 1..10
    end
  end

  assign cipherText  = stateReg;  // held until next start
  assign cipherValid = (fsm == finish);

  // single valid pulse eleven cycles after start
  validSingle: assert property (
    @(posedge clk) disable iff (reset) start |-> ##11 cipherValid ##1 !cipherValid
  );

  // register block must hold off start until the core is idle
  startWhenIdle: assert property (
    @(posedge clk) disable iff (reset) start |-> (fsm == idle)
  );

endmodule

//--- source/aesKeySchedule.sv
// on-the-fly AES-128 key expansion
//   one round key per clock after start
//   round counter and rcon register
//   finalRound flag while round key 10 is presented

`timescale 1ns/1ps

module aesKeySchedule (
  input  logic           clk,
  input  logic           reset,
  input  logic           start,
  input  aesPkg::block_t cipherKey,
  output aesPkg::block_t roundKey,
  output logic           finalRound
);

  aesPkg::roundCount_t roundCnt;  // 0 when idle or 1..10 for the key presented
  aesPkg::byte_t       rconReg;   // rcon for the next expansion
  aesPkg::block_t      nextKey;
  logic                running;

  // one expansion step over the four columns
  function automatic aesPkg::block_t expandKey(aesPkg::block_t key, aesPkg::byte_t rcon);
    aesPkg::word_t w0, w1, w2, w3, rotSub;
    w0 = key[127:96];
    w1 = key[95:64];
    w2 = key[63:32];
    w3 = key[31:0];
    // RotWord and SubWord on the last column with rcon in the top byte
    rotSub = {aesPkg::sbox(w3[23:16]) ^ rcon, aesPkg::sbox(w3[15:8]),
              aesPkg::sbox(w3[7:0]), aesPkg::sbox(w3[31:24])};
    w0 = w0 ^ rotSub;
    w1 = w1 ^ w0;  // xor chain
    w2 = w2 ^ w1;
    w3 = w3 ^ w2;
    return {w0, w1, w2, w3};
  endfunction

  // start expands the fresh key while later steps chain on
  assign nextKey = start ? expandKey(cipherKey, aesPkg::rconInit)
                         : expandKey(roundKey, rconReg);

  assign running    = (roundCnt != '0) && (roundCnt != aesPkg::numRounds);
  assign finalRound = (roundCnt == aesPkg::numRounds);

  always_ff @(posedge clk) begin
    if (reset) begin
      roundCnt <= '0;
      rconReg  <= aesPkg::rconInit;
    end else if (start) begin
      roundCnt <= 4'd1;  // round key 1 next cycle
      rconReg  <= aesPkg::rconNext(aesPkg::rconInit);
    end else if (running) begin
      roundCnt <= roundCnt + 4'd1;
      rconReg  <= aesPkg::rconNext(rconReg);
    end else if (finalRound) begin
      roundCnt <= '0;  // back to idle with the key held
    end
  end

  // round key register loads on start and while running
  always_ff @(posedge clk) begin
    if (start || running) begin
      roundKey <= nextKey;
    end
  end

  // counter stays in range across whole run
  roundCntRange: assert property (
    @(posedge clk) disable iff (reset) roundCnt <= aesPkg::numRounds
  );

endmodule

//--- source/aesPkg.sv
// shared AES-128 definitions
//   vector types for blocks, words, bytes, APB addresses, round index
//   APB register map addresses
//   forward S-box table lookup and round constant doubling

package aesPkg;

  typedef logic [127:0] block_t;     // state, key, text
  typedef logic [31:0]  word_t;      // APB word or key column
  typedef logic [7:0]   byte_t;
  typedef logic [7:0]   apbAddr_t;   // byte address
  typedef logic [3:0]   roundCount_t;

  localparam roundCount_t numRounds = 4'd10;
  localparam byte_t       rconInit  = 8'h01;  // rcon of round 1

  // register map, byte addresses
  localparam apbAddr_t addrKey    = 8'h00;  // 4 words, msw first
  localparam apbAddr_t addrPlain  = 8'h10;  // 4 words
  localparam apbAddr_t addrCipher = 8'h20;  // 4 words, read only
  localparam apbAddr_t addrCtrl   = 8'h30;  // bit 0 starts
  localparam apbAddr_t addrStatus = 8'h34;  // bit 0 busy, bit 1 done

  // forward S-box, entry 0 in the top byte, one table row per line
  localparam logic [0:255][7:0] sboxTable = {
    128'h637c777bf26b6fc53001672bfed7ab76,
    128'hca82c97dfa5947f0add4a2af9ca472c0,
    128'hb7fd9326363ff7cc34a5e5f171d83115,
    128'h04c723c31896059a071280e2eb27b275,
    128'h09832c1a1b6e5aa0523bd6b329e32f84,
    128'h53d100ed20fcb15b6acbbe394a4c58cf,
    128'hd0efaafb434d338545f9027f503c9fa8,
    128'h51a3408f929d38f5bcb6da2110fff3d2,
    128'hcd0c13ec5f974417c4a77e3d645d1973,
    128'h60814fdc222a908846eeb814de5e0bdb,
    128'he0323a0a4906245cc2d3ac629195e479,
    128'he7c8376d8dd54ea96c56f4ea657aae08,
    128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
    128'h703eb5664803f60e613557b986c11d9e,
    128'he1f8981169d98e949b1e87e9ce5528df,
    128'h8ca1890dbfe6426841992d0fb054bb16
  };

  // SubBytes for one byte
  function automatic byte_t sbox(byte_t b);
    return sboxTable[b];
  endfunction

  // multiply by x in GF(2^8), reduction poly 0x11b
  function automatic byte_t rconNext(byte_t r);
    return {r[6:0], 1'b0} ^ (r[7] ? 8'h1b : 8'h00);
  endfunction

endpackage
